//--- build.f
+incdir+testbench
hdl/sample_pkg.sv
hdl/link_pkg.sv
hdl/rx_if.sv
hdl/reader_demod.sv
hdl/tag_demod.sv
hdl/ssp_framer.sv
hdl/hi_iso14443a.sv
testbench/tb_hi_iso14443a.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator, run it and check the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_hi_iso14443a -f build.f \
	--Mdir "$build_dir" -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

"./$build_dir/sim_tb" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

//--- testbench/tb_tasks.svh
// testbench tasks for the receive front end
// value check, drive and capture helpers, and the directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------------------------
// check and drive helpers
// ----------------------------------------------------------
task automatic check_eq(input string what, input int expected, input int actual);
	if (expected != actual)
	begin
		errors = errors + 1;
		$display("FAILED %s, %s: expected %0d (0x%0h), actual %0d (0x%0h)",
			cur_test, what, expected, expected, actual, actual);
		$display("sim failed");
		$fatal(1, "value mismatch in %s", cur_test);
	end
endtask

// inputs change one time unit after the rising clock edge
task automatic set_level(input adc_sample_t level);
	@(posedge adc_clk);
	#1;
	square_en = 1'b0;
	adc_d = level;
endtask

task automatic start_square();
	@(posedge adc_clk);
	#1;
	square_cnt = 0;
	square_en = 1'b1;
endtask

task automatic set_mode(input hf_mode_t mode);
	@(posedge adc_clk);
	#1;
	mod_type = mode;
endtask

// ----------------------------------------------------------
// link observation
// ----------------------------------------------------------
function automatic logic link_sig(input int sel);
	return (sel == sel_clk) ? ssp_clk : ssp_frame;
endfunction

// link outputs are looked at on falling adc_clk edges, half a cycle
// away from the edge that updates them
task automatic wait_edge(input int sel, input logic level);
	logic prev;
	logic seen;
	prev = link_sig(sel);
	seen = 1'b0;
	while (!seen)
	begin
		@(negedge adc_clk);
		seen = (prev != level) && (link_sig(sel) == level);
		prev = link_sig(sel);
	end
endtask

task automatic skip_frames(input int count);
	repeat (count)
		wait_edge(sel_frame, 1'b1);
endtask

// takes one byte as the host sees it with the MSB first and one bit per falling ssp_clk
task automatic capture_byte(output logic [7:0] value);
	value = '0;
	wait_edge(sel_frame, 1'b1);
	for (int i = 0; i < 8; i++)
	begin
		wait_edge(sel_clk, 1'b0);
		value = {value[6:0], ssp_din};
	end
endtask

// distance in cycles between successive rises of a link signal
task automatic measure_period(input string what, input int sel, input int expected,
	input int count);
	int last;
	wait_edge(sel, 1'b1);
	last = cycle;
	repeat (count)
	begin
		wait_edge(sel, 1'b1);
		check_eq(what, expected, cycle - last);
		last = cycle;
	end
endtask

task automatic expect_din_at_falls(input string what, input logic expected,
	input int count);
	repeat (count)
	begin
		wait_edge(sel_clk, 1'b0);
		check_eq(what, int'(expected), int'(ssp_din));
	end
endtask

// ----------------------------------------------------------
// directed tests
// ----------------------------------------------------------
// all three link outputs are cleared by reset and stay so until
// the first edge that sees reset low
task automatic test_reset();
	cur_test = "test_reset";
	fdt_reset = 1'b1;
	repeat (2)
	begin
		@(posedge adc_clk);
		#1;
		check_eq("ssp_clk in reset", 0, int'(ssp_clk));
		check_eq("ssp_frame in reset", 0, int'(ssp_frame));
		check_eq("ssp_din in reset", 0, int'(ssp_din));
	end
	fdt_reset = 1'b0;
	@(negedge adc_clk);
	check_eq("ssp_clk after reset", 0, int'(ssp_clk));
	check_eq("ssp_frame after reset", 0, int'(ssp_frame));
	check_eq("ssp_din after reset", 0, int'(ssp_din));
endtask

// sniffer link runs at adc_clk/8 with a frame every 64 cycles
task automatic test_sniff_link_timing();
	int last;
	cur_test = "test_sniff_link_timing";
	set_mode(mode_sniffer);
	skip_frames(2);
	measure_period("ssp_clk period", sel_clk, 8, 16);
	measure_period("ssp_frame period", sel_frame, 64, 4);
	wait_edge(sel_frame, 1'b1);
	last = cycle;
	wait_edge(sel_frame, 1'b0);
	check_eq("ssp_frame high time", 8, cycle - last);
endtask

// reader nibble follows the carrier, tag nibble is zero for flat input
// and forced to zero while the reader is active
task automatic test_sniff_carrier();
	logic [7:0] value;
	cur_test = "test_sniff_carrier";
	set_mode(mode_sniffer);
	set_level(8'd200);
	skip_frames(2);
	capture_byte(value);
	check_eq("steady carrier byte", 8'hF0, int'(value));

	set_level(8'd0);
	skip_frames(4);
	capture_byte(value);
	check_eq("reader pause byte", 8'h00, int'(value));

	// six frames cover the 256 cycle quiet run plus a full nibble
	set_level(8'd200);
	skip_frames(6);
	capture_byte(value);
	check_eq("restored carrier byte", 8'hF0, int'(value));
endtask

// levels from 8 to 15 sit inside the Schmitt trigger band and hold it
task automatic test_sniff_hysteresis();
	logic [7:0] value;
	logic base_high;
	adc_sample_t level;
	cur_test = "test_sniff_hysteresis";
	set_mode(mode_sniffer);
	repeat (4)
	begin
		base_high = (($urandom % 2) == 1);
		set_level(base_high ? 8'd200 : 8'd0);
		skip_frames(2);
		level = adc_sample_t'(8 + ($urandom % 8));
		set_level(level);
		skip_frames(2);
		capture_byte(value);
		check_eq("reader nibble", base_high ? 4'hF : 4'h0, int'(value[7:4]));
	end
endtask

// both a rise and a fall in each window give a tag bit of 1
task automatic test_listen_tag_modulation();
	cur_test = "test_listen_tag_modulation";
	set_mode(mode_reader_listen);
	start_square();
	skip_frames(2);
	expect_din_at_falls("square wave tag bit", 1'b1, 16);

	set_level(8'd100);
	skip_frames(2);
	expect_din_at_falls("flat level tag bit", 1'b0, 16);

	measure_period("ssp_clk period", sel_clk, 16, 8);
	measure_period("ssp_frame period", sel_frame, 128, 3);
endtask

// the tag demodulator keeps seeing modulation here, yet the link must stay silent
task automatic test_idle_mode();
	cur_test = "test_idle_mode";
	set_mode(mode_idle);
	start_square();
	skip_frames(2);
	repeat (256)
	begin
		@(negedge adc_clk);
		check_eq("ssp_din in idle", 0, int'(ssp_din));
	end
	measure_period("ssp_clk period", sel_clk, 16, 8);
endtask

`endif

//--- testbench/tb_hi_iso14443a.sv
// testbench top for the ISO14443-A receive front end
// clock, reset, DUT, square wave source, timeout and the test sequence
module tb_hi_iso14443a
	import sample_pkg::*, link_pkg::*;
();

	// adc_clk period is 4 time units
	localparam int clk_half = 2;
	// the tests take roughly 5300 cycles in all (sniffer timing 650,
	// carrier 960, hysteresis 1280, reader-listen 1680, idle 660),
	// so this limit leaves close to four times that
	localparam int timeout_cycles = 20000;
	// selectors for the link signals watched by the edge helpers
	localparam int sel_clk = 0;
	localparam int sel_frame = 1;

	logic adc_clk;
	logic fdt_reset;
	adc_sample_t adc_d;
	hf_mode_t mod_type;
	logic ssp_clk;
	logic ssp_frame;
	logic ssp_din;

	// cycles since the start of the run, read at falling adc_clk edges
	int cycle;
	int errors;
	string cur_test;
	// background square wave for the tag modulation test
	logic square_en;
	int square_cnt;

	hi_iso14443a DUT (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.mod_type  (mod_type),
		.ssp_clk   (ssp_clk),
		.ssp_frame (ssp_frame),
		.ssp_din   (ssp_din)
	);

	`include "tb_tasks.svh"

	// ----------------------------------------------------------
	// clock, timeout and stimulus source
	// ----------------------------------------------------------
	initial
	begin
		adc_clk = 1'b0;
		forever #clk_half adc_clk = ~adc_clk;
	end

	always @(posedge adc_clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles)
		begin
			$display("timeout, the tests did not finish within %0d cycles", timeout_cycles);
			$display("sim failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// 8 samples low and 8 samples high, one full period per 16-cycle bit
	always @(posedge adc_clk)
	begin
		#1;
		if (square_en)
		begin
			adc_d = (square_cnt < 8) ? 8'd20 : 8'd100;
			square_cnt = (square_cnt + 1) % 16;
		end
	end

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial
	begin
		cycle = 0;
		errors = 0;
		cur_test = "none";
		fdt_reset = 1'b1;
		adc_d = 8'd200;
		mod_type = mode_idle;
		square_en = 1'b0;
		square_cnt = 0;
		void'($urandom(32'h99e0_ee6e));

		test_reset();
		test_sniff_link_timing();
		test_sniff_carrier();
		test_sniff_hysteresis();
		test_listen_tag_modulation();
		test_idle_mode();

		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- hdl/hi_iso14443a.sv
// ISO14443-A receive front end, top level
// reader and tag demodulators joined to the SSP framer
module hi_iso14443a
	import sample_pkg::*, link_pkg::*;
(
	input  logic        adc_clk,
	input  logic        fdt_reset,
	input  adc_sample_t adc_d,
	input  hf_mode_t    mod_type,
	output logic        ssp_clk,
	output logic        ssp_frame,
	output logic        ssp_din
);

	// shared demodulator state and the bit phase
	rx_if rx ();

	// ----------------------------------------------------------
	// demodulators
	// ----------------------------------------------------------
	// reader pauses come from the field level alone
	reader_demod u_reader_demod (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.rx        (rx.reader)
	);

	// tag load modulation needs the mode for its window timing
	tag_demod u_tag_demod (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.adc_d     (adc_d),
		.mod_type  (mod_type),
		.rx        (rx.tag)
	);

	// ----------------------------------------------------------
	// host link
	// ----------------------------------------------------------
	ssp_framer u_ssp_framer (
		.adc_clk   (adc_clk),
		.fdt_reset (fdt_reset),
		.mod_type  (mod_type),
		.rx        (rx.framer),
		.ssp_clk   (ssp_clk),
		.ssp_frame (ssp_frame),
		.ssp_din   (ssp_din)
	);

endmodule

//--- hdl/ssp_framer.sv
// SSP framer toward the host
// free running bit phase, reader and tag bit sampling, sniffer byte
// assembly and shift, SSP clock, frame and data for each mode
module ssp_framer
	import link_pkg::*;
(
	input  logic     adc_clk,
	input  logic     fdt_reset,
	input  hf_mode_t mod_type,
	rx_if.framer     rx,
	output logic     ssp_clk,
	output logic     ssp_frame,
	output logic     ssp_din
);

	phase_t phase;
	slot_t slot;
	logic sniff;
	nibble_t reader_hist;
	nibble_t tag_hist;
	ssp_byte_t sniff_byte;
	logic listen_bit;

	// ----------------------------------------------------------
	// bit phase
	// ----------------------------------------------------------
	// 128 cycles hold a full byte at the slow rate; wraps on its own
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			phase <= '0;
		else
			phase <= phase + 7'd1;
	end

	assign rx.phase = phase;
	assign slot = phase[3:0];
	assign sniff = (mod_type == mode_sniffer);

	// ----------------------------------------------------------
	// bit sampling
	// ----------------------------------------------------------
	// one reader bit and one tag bit per 16 cycles, four of each per byte
	always_ff @(posedge adc_clk)
	begin
		if (slot == bit_sample_slot)
		begin
			reader_hist <= {reader_hist[2:0], rx.carrier_on};
			tag_hist <= {tag_hist[2:0], rx.tag_bit};
		end
	end

	// in reader-listen mode one tag bit is held for a whole bit time
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			listen_bit <= 1'b0;
		else if (slot == bit_sample_slot)
			listen_bit <= rx.tag_bit;
	end

	// ----------------------------------------------------------
	// sniffer byte
	// ----------------------------------------------------------
	// the byte loads one cycle before the frame starts and then shifts at
	// twice the bit rate, so 8 bits leave in one 64 cycle frame
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			sniff_byte <= '0;
		else if (sniff)
		begin
			if (phase[5:0] == sniff_load_pos)
			begin
				// while the reader talks the tag half is only noise from its pauses
				if (rx.reader_active)
					sniff_byte <= {reader_hist, 4'h0};
				else
					sniff_byte <= {reader_hist, tag_hist};
			end
			else if (phase[2:0] == sniff_clk_high && phase[5:0] != sniff_frame_high)
			begin
				// the first bit of the frame must stay put for its full clock
				sniff_byte <= {sniff_byte[6:0], 1'b0};
			end
		end
	end

	// ----------------------------------------------------------
	// SSP clock and frame
	// ----------------------------------------------------------
	// the host takes data on the falling clock edge
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			ssp_clk <= 1'b0;
			ssp_frame <= 1'b0;
		end
		else if (sniff)
		begin
			if (phase[2:0] == sniff_clk_high)
				ssp_clk <= 1'b1;
			else if (phase[2:0] == sniff_clk_low)
				ssp_clk <= 1'b0;

			if (phase[5:0] == sniff_frame_high)
				ssp_frame <= 1'b1;
			else if (phase[5:0] == sniff_frame_low)
				ssp_frame <= 1'b0;
		end
		else
		begin
			if (slot == link_clk_high)
				ssp_clk <= 1'b1;
			else if (slot == link_clk_low)
				ssp_clk <= 1'b0;

			// frame straddles the first falling clock edge of the byte
			if (phase == link_frame_high)
				ssp_frame <= 1'b1;
			else if (phase == link_frame_low)
				ssp_frame <= 1'b0;
		end
	end

	// data source by mode, zero when nothing is being sent
	always_comb
	begin
		case (mod_type)
			mode_sniffer:
				ssp_din = sniff_byte[7];
			mode_reader_listen:
				ssp_din = listen_bit;
			default:
				ssp_din = 1'b0;
		endcase
	end

	// the host aligns bytes on a frame rise, which must meet a high clock
	frame_rise_on_clk: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		$rose(ssp_frame) && $past(mod_type) == mode_sniffer |-> ssp_clk)
		else $error("sniffer frame rose while ssp_clk was low");

endmodule

//--- hdl/tag_demod.sv
// tag side demodulator
// sample history and derivative filter, per window tracking of the
// steepest edges, the tag bit decision and the window placement
module tag_demod
	import sample_pkg::*, link_pkg::*;
(
	input  logic        adc_clk,
	input  logic        fdt_reset,
	input  adc_sample_t adc_d,
	input  hf_mode_t    mod_type,
	rx_if.tag           rx
);

	adc_sample_t prev_1;
	adc_sample_t prev_2;
	adc_sample_t prev_3;
	adc_sample_t prev_4;
	logic [9:0] older_sum;
	logic [9:0] newer_sum;
	filt_t filt;
	filt_t pos_max;
	filt_t neg_min;
	slot_t slot;
	slot_t window_start;
	logic window_end;

	// ----------------------------------------------------------
	// derivative filter
	// ----------------------------------------------------------
	// four samples back are enough for the five tap kernel
	always_ff @(posedge adc_clk)
	begin
		prev_4 <= prev_3;
		prev_3 <= prev_2;
		prev_2 <= prev_1;
		prev_1 <= adc_d;
	end

	// kernel is 2, 1, 0, -1, -2 from oldest to newest sample
	// so a falling level gives a positive output and a rising one a negative
	assign older_sum = {1'b0, prev_4, 1'b0} + {2'b00, prev_3};
	assign newer_sum = {1'b0, adc_d, 1'b0} + {2'b00, prev_1};
	assign filt = filt_t'({1'b0, older_sum}) - filt_t'({1'b0, newer_sum});

	// ----------------------------------------------------------
	// window placement
	// ----------------------------------------------------------
	assign slot = rx.phase[3:0];

	// when listening as a reader our own pauses fix the answer timing,
	// when sniffing we lock to the end of the other reader's pause
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
			window_start <= '0;
		else
		begin
			case (mod_type)
				mode_reader_listen:
					window_start <= listen_window_start;
				mode_sniffer:
					if (rx.carrier_rise && rx.reader_active)
						window_start <= slot - sniff_sync_offset;
				default:
					window_start <= window_start;
			endcase
		end
	end

	assign window_end = (slot == window_start);

	// ----------------------------------------------------------
	// modulation detector
	// ----------------------------------------------------------
	// a modulated bit has both a falling and a rising edge inside the window,
	// the order does not matter
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			rx.tag_bit <= 1'b0;
			pos_max <= '0;
			neg_min <= '0;
		end
		else if (window_end)
		begin
			rx.tag_bit <= (pos_max > edge_threshold) && (neg_min < -edge_threshold);
			pos_max <= '0;
			neg_min <= '0;
		end
		else if (filt > 0)
		begin
			if (filt > pos_max)
				pos_max <= filt;
		end
		else if (filt < neg_min)
		begin
			neg_min <= filt;
		end
	end

	extremes_keep_sign: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		(pos_max >= 0) && (neg_min <= 0))
		else $error("edge extremes crossed zero");

endmodule

//--- hdl/reader_demod.sv
// reader side demodulator
// Schmitt trigger on the ADC samples, rising edge detect,
// and the deep modulation FSM that marks reader activity
module reader_demod
	import sample_pkg::*;
(
	input  logic        adc_clk,
	input  logic        fdt_reset,
	input  adc_sample_t adc_d,
	rx_if.reader        rx
);

	logic carrier_prev;
	logic sample_zero;
	carrier_state_t state;
	deep_cnt_t zero_cnt;
	quiet_cnt_t quiet_cnt;

	// ----------------------------------------------------------
	// Schmitt trigger
	// ----------------------------------------------------------
	// the reader modulates 100%, so the field is either there or not;
	// the hysteresis keeps slow ramps of the carrier from toggling it
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			rx.carrier_on <= 1'b1;
			carrier_prev <= 1'b1;
		end
		else
		begin
			if (adc_d >= hyst_high)
				rx.carrier_on <= 1'b1;
			else if (adc_d < hyst_low)
				rx.carrier_on <= 1'b0;
			carrier_prev <= rx.carrier_on;
		end
	end

	// end of a pause is where the tag's answer is timed from
	assign rx.carrier_rise = rx.carrier_on & ~carrier_prev;

	// ----------------------------------------------------------
	// deep modulation FSM
	// ----------------------------------------------------------
	assign sample_zero = (adc_d == '0);

	// both counters saturate at their last value so a long run holds
	always_ff @(posedge adc_clk)
	begin
		if (fdt_reset)
		begin
			state <= carrier_idle;
			zero_cnt <= '0;
			quiet_cnt <= '0;
		end
		else
		begin
			if (sample_zero)
			begin
				quiet_cnt <= '0;
				if (zero_cnt != deep_cnt_t'(deep_run - 1))
					zero_cnt <= zero_cnt + 3'd1;
			end
			else
			begin
				zero_cnt <= '0;
				if (quiet_cnt != quiet_cnt_t'(quiet_run - 1))
					quiet_cnt <= quiet_cnt + 8'd1;
			end

			case (state)
				// a pause of eight zero samples means a reader is talking
				carrier_idle:
					if (sample_zero && zero_cnt == deep_cnt_t'(deep_run - 1))
						state <= carrier_modulated;
				// a long steady carrier means it went quiet, likely waiting for the tag
				carrier_modulated:
					if (!sample_zero && quiet_cnt == quiet_cnt_t'(quiet_run - 1))
						state <= carrier_idle;
				default:
					state <= carrier_idle;
			endcase
		end
	end

	assign rx.reader_active = (state == carrier_modulated);

	// a rise pulse needs the carrier on and a sample at or above the upper level
	// one cycle before it
	rise_follows_high_sample: assert property (@(posedge adc_clk) disable iff (fdt_reset)
		rx.carrier_rise |-> rx.carrier_on && $past(adc_d) >= hyst_high)
		else $error("carrier_rise without a sample at or above the upper threshold");

endmodule

//--- hdl/rx_if.sv
// rx_if interface between the two demodulators and the SSP framer
// carrier state, reader activity, tag bit and the shared bit phase
interface rx_if
	import link_pkg::*;
();

	// Schmitt trigger output, 1 while the field is present
	logic carrier_on;
	// single cycle pulse at the end of a reader pause
	logic carrier_rise;
	// the reader is currently sending
	logic reader_active;
	// load modulation seen during the last window
	logic tag_bit;
	// free running bit phase from the framer
	phase_t phase;

	// the reader side produces everything about the field itself
	modport reader (
		output carrier_on,
		output carrier_rise,
		output reader_active
	);

	// the tag side syncs its window to the reader's pauses
	modport tag (
		input  carrier_rise,
		input  reader_active,
		input  phase,
		output tag_bit
	);

	modport framer (
		input  carrier_on,
		input  reader_active,
		input  tag_bit,
		output phase
	);

endinterface

//--- hdl/link_pkg.sv
// link domain definitions for the SSP side
// mode codes, phase counter and slot types, byte types,
// tag window positions and the SSP clock and frame timing
package link_pkg;

	// bit phase, one full reader-listen frame is 128 cycles
	typedef logic [6:0] phase_t;
	// position inside one 16-cycle bit
	typedef logic [3:0] slot_t;
	// one nibble of sampled bits and one byte on the SSP link
	typedef logic [3:0] nibble_t;
	typedef logic [7:0] ssp_byte_t;

	// the codes follow mod_type; anything not listed is treated as idle
	typedef enum logic [2:0] {
		mode_idle = 3'd0,
		mode_reader_listen = 3'd3,
		mode_sniffer = 3'd4
	} hf_mode_t;

	// tag detection window placement
	localparam slot_t listen_window_start = 4'd4;
	localparam slot_t sniff_sync_offset = 4'd3;
	// slot where the reader and tag bits are taken
	localparam slot_t bit_sample_slot = 4'd0;

	// ----------------------------------------------------------
	// SSP timing
	// ----------------------------------------------------------
	// sniffer link, clock is adc_clk/8 and frame is adc_clk/64
	localparam logic [2:0] sniff_clk_high = 3'd0;
	localparam logic [2:0] sniff_clk_low = 3'd4;
	localparam logic [5:0] sniff_frame_high = 6'd0;
	localparam logic [5:0] sniff_frame_low = 6'd8;
	localparam logic [5:0] sniff_load_pos = 6'd63;
	// every other mode, clock is adc_clk/16 and frame is adc_clk/128
	localparam slot_t link_clk_high = 4'd0;
	localparam slot_t link_clk_low = 4'd8;
	localparam phase_t link_frame_high = 7'd7;
	localparam phase_t link_frame_low = 7'd23;

endpackage

//--- hdl/sample_pkg.sv
// sample domain definitions for the receive path
// ADC sample and filter types, Schmitt trigger levels,
// reader pause run lengths and the tag edge threshold
package sample_pkg;

	// ----------------------------------------------------------
	// data types
	// ----------------------------------------------------------

	// one unsigned ADC sample of the rectified field
	typedef logic [7:0] adc_sample_t;
	// signed output of the derivative filter, wide enough for 3*255 either way
	typedef logic signed [10:0] filt_t;
	// run counters of the deep modulation detector
	typedef logic [2:0] deep_cnt_t;
	typedef logic [7:0] quiet_cnt_t;

	// state of the reader's carrier as seen by the pause detector
	typedef enum logic {
		carrier_idle,
		carrier_modulated
	} carrier_state_t;

	// ----------------------------------------------------------
	// thresholds
	// ----------------------------------------------------------

	// Schmitt trigger levels; samples in between keep the last decision
	localparam adc_sample_t hyst_high = 8'd16;
	localparam adc_sample_t hyst_low = 8'd8;
	// a reader pause is this many zero samples in a row
	localparam int deep_run = 8;
	// reader activity ends after this many nonzero samples in a row
	localparam int quiet_run = 256;
	// smallest filter magnitude that counts as a load modulation edge
	localparam filt_t edge_threshold = 11'sd5;

endpackage
